// File: src/IFetchPkg.sv
package IFetchPkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int WAYS = 2;
    localparam int SETS = 16;
    localparam int LINE_WORDS = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int ID_W = 8;

    // address fields, low to high: byte, word, set, tag
    localparam int BYTE_OFF_W = $clog2(WORD_W / 8);
    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);
    localparam int LINE_OFF_W = OFF_W + BYTE_OFF_W;
    localparam int TAG_W = ADDR_W - SET_W - LINE_OFF_W;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [ADDR_W-1:0] Addr;
    typedef logic [WORD_W-1:0] Word;
    typedef logic [SET_W-1:0] SetIdx;
    typedef logic [WAY_W-1:0] WayIdx;
    typedef logic [OFF_W-1:0] WordOff;
    typedef logic [TAG_W-1:0] Tag;
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] Line;
    typedef logic [ID_W-1:0] FetchId;
    typedef logic [QPTR_W-1:0] QueuePtr;
    typedef logic [QPTR_W:0] QueueCount;

    typedef enum logic [1:0] {
        IDLE,
        QUEUED,
        ACTIVE,
        FINALIZE
    } FlushState;

    function automatic SetIdx pcSet(Addr pc);
        return pc[LINE_OFF_W +: SET_W];
    endfunction

    function automatic Tag pcTag(Addr pc);
        return pc[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic WordOff pcOff(Addr pc);
        return pc[BYTE_OFF_W +: OFF_W];
    endfunction

    function automatic Addr lineAddr(Addr pc);
        return {pc[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    endfunction

endpackage

// File: src/FlushControl.sv
module FlushControl (
    input  logic clk,
    input  logic rst,
    input  logic clearCache,
    input  logic pipeEmpty,
    input  logic memBusy,
    input  logic counterDone,
    output logic flushActive,
    output logic flushBusy,
    output logic counterRun
);
    import IFetchPkg::*;

    FlushState state;
    FlushState stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (clearCache) stateNext = QUEUED;
            end
            QUEUED: begin
                // nothing may be in flight while tags are cleared
                if (pipeEmpty) stateNext = ACTIVE;
            end
            ACTIVE: begin
                if (counterDone) stateNext = memBusy ? FINALIZE : IDLE;
            end
            FINALIZE: begin
                if (!memBusy) stateNext = IDLE;
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    // reset goes straight into a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= QUEUED;
        end else begin
            state <= stateNext;
        end
    end

    assign flushActive = state == ACTIVE;
    assign flushBusy = state != IDLE;

    // counter stops on the last entry, which also returns it to zero
    assign counterRun = flushActive && !counterDone;

endmodule

// File: src/FlushCounter.sv
module FlushCounter (
    input  logic clk,
    input  logic rst,
    input  logic counterRun,
    output IFetchPkg::WayIdx flushWay,
    output IFetchPkg::SetIdx flushSet,
    output logic counterDone
);
    import IFetchPkg::*;

    // way in the upper bits, set in the lower bits
    logic [WAY_W+SET_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || !counterRun) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign flushWay = count[SET_W +: WAY_W];
    assign flushSet = count[SET_W-1:0];

    // last entry, next step wraps
    assign counterDone = &count;

endmodule

// File: src/ICacheTags.sv
module ICacheTags (
    input  logic clk,
    input  logic rst,
    input  logic readEn,
    input  IFetchPkg::SetIdx readSet,
    input  IFetchPkg::Tag readTag,
    input  logic writeEn,
    input  IFetchPkg::SetIdx writeSet,
    input  IFetchPkg::WayIdx writeWay,
    input  logic writeValid,
    input  IFetchPkg::Tag writeTag,
    output logic hit,
    output IFetchPkg::WayIdx hitWay
);
    import IFetchPkg::*;

    Tag tagMem [WAYS][SETS];
    logic validMem [WAYS][SETS];

    Tag fwdTag [WAYS];
    logic [WAYS-1:0] fwdValid;
    Tag rdTag [WAYS];
    logic [WAYS-1:0] rdValid;
    Tag cmpTag;
    logic [WAYS-1:0] match;

    always_ff @(posedge clk) begin
        if (writeEn) begin
            tagMem[writeWay][writeSet] <= writeTag;
            validMem[writeWay][writeSet] <= writeValid;
        end
    end

    // a refill written on the same edge is seen by the re-read
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            if (writeEn && writeWay == WayIdx'(w) && writeSet == readSet) begin
                fwdTag[w] = writeTag;
                fwdValid[w] = writeValid;
            end else begin
                fwdTag[w] = tagMem[w][readSet];
                fwdValid[w] = validMem[w][readSet];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= '0;
        end else if (readEn) begin
            rdValid <= fwdValid;
        end
    end

    always_ff @(posedge clk) begin
        if (readEn) begin
            rdTag <= fwdTag;
            cmpTag <= readTag;
        end
    end

    always_comb begin
        hitWay = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = rdValid[w] && rdTag[w] == cmpTag;
            if (match[w]) hitWay = WayIdx'(w);
        end
    end

    assign hit = |match;

endmodule

// File: src/ICacheData.sv
module ICacheData (
    input  logic clk,
    input  logic readEn,
    input  IFetchPkg::SetIdx readSet,
    input  logic writeEn,
    input  IFetchPkg::SetIdx writeSet,
    input  IFetchPkg::WayIdx writeWay,
    input  IFetchPkg::Line writeLine,
    output IFetchPkg::Line [IFetchPkg::WAYS-1:0] readLines
);
    import IFetchPkg::*;

    Line lineMem [WAYS][SETS];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            lineMem[writeWay][writeSet] <= writeLine;
        end
    end

    // all ways of the set, the pipeline picks the word after the compare
    always_ff @(posedge clk) begin
        if (readEn) begin
            for (int w = 0; w < WAYS; w++) begin
                readLines[w] <= lineMem[w][readSet];
            end
        end
    end

endmodule

// File: src/FetchPipeline.sv
module FetchPipeline (
    input  logic clk,
    input  logic rst,
    input  logic fetchValid,
    input  IFetchPkg::Addr fetchPc,
    input  logic flushBusy,
    input  logic hit,
    input  IFetchPkg::WayIdx hitWay,
    input  IFetchPkg::Line [IFetchPkg::WAYS-1:0] readLines,
    input  logic memRespValid,
    input  IFetchPkg::Line memRespData,
    input  IFetchPkg::QueueCount freeCount,
    output logic stall,
    output logic pipeEmpty,
    output logic tagReadEn,
    output IFetchPkg::SetIdx tagSet,
    output IFetchPkg::Tag tagCmp,
    output logic tagWe,
    output IFetchPkg::WayIdx tagWay,
    output IFetchPkg::Tag tagWriteTag,
    output logic dataWe,
    output logic memReq,
    output IFetchPkg::Addr memReqAddr,
    output logic pushValid,
    output IFetchPkg::Addr pushPc,
    output IFetchPkg::Word pushInstr,
    output IFetchPkg::FetchId pushId
);
    import IFetchPkg::*;

    logic s0Valid;
    logic s1Valid;
    Addr s0Pc;
    Addr s1Pc;
    logic missPending;
    logic fillBypass;
    Word fillWord;
    WayIdx victimWay;
    FetchId nextId;

    logic accept;
    logic s1Hit;
    logic s1Miss;
    logic s1Free;
    logic s0Move;
    logic refill;
    logic newMiss;
    logic spaceLow;

    assign refill = missPending && memRespValid;
    assign newMiss = s1Miss && !missPending;

    assign s1Hit = s1Valid && hit;
    assign s1Miss = s1Valid && !hit;
    assign s1Free = !s1Valid || hit;
    assign s0Move = s0Valid && s1Free;

    // every op in a stage has a queue slot reserved
    assign spaceLow = freeCount <= QueueCount'(s0Valid) + QueueCount'(s1Valid);

    assign stall = flushBusy || s1Miss || spaceLow;
    assign accept = fetchValid && !stall;
    assign pipeEmpty = !s0Valid && !s1Valid;

    // stage 0 reads the arrays, a refill re-reads the set of stage 1
    assign tagReadEn = refill || s0Move;
    assign tagSet = refill ? pcSet(s1Pc) : pcSet(s0Pc);
    assign tagCmp = refill ? pcTag(s1Pc) : pcTag(s0Pc);

    assign tagWe = refill;
    assign tagWay = victimWay;
    assign tagWriteTag = pcTag(s1Pc);
    assign dataWe = refill;

    assign pushValid = s1Hit;
    assign pushPc = s1Pc;
    assign pushId = nextId;

    // data array has no write forwarding, so the re-check takes the refill word
    assign pushInstr = fillBypass ? fillWord : readLines[hitWay][pcOff(s1Pc)];

    always_ff @(posedge clk) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            missPending <= 1'b0;
            memReq <= 1'b0;
            fillBypass <= 1'b0;
            victimWay <= '0;
            nextId <= '0;
        end else begin
            if (accept) begin
                s0Valid <= 1'b1;
            end else if (s0Move) begin
                s0Valid <= 1'b0;
            end

            // stage 1 holds on a miss
            if (s1Free) s1Valid <= s0Move;

            memReq <= newMiss;
            if (newMiss) begin
                missPending <= 1'b1;
            end else if (refill) begin
                missPending <= 1'b0;
            end

            fillBypass <= refill;

            // global round robin
            if (refill) victimWay <= victimWay + 1'b1;

            if (s1Hit) nextId <= nextId + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) s0Pc <= fetchPc;
        if (s0Move) s1Pc <= s0Pc;
        if (newMiss) memReqAddr <= lineAddr(s1Pc);
        if (refill) fillWord <= memRespData[pcOff(s1Pc)];
    end

endmodule

// File: src/FetchQueue.sv
module FetchQueue (
    input  logic clk,
    input  logic rst,
    input  logic pushValid,
    input  IFetchPkg::Addr pushPc,
    input  IFetchPkg::Word pushInstr,
    input  IFetchPkg::FetchId pushId,
    input  logic outReady,
    output logic outValid,
    output IFetchPkg::Addr outPc,
    output IFetchPkg::Word outInstr,
    output IFetchPkg::FetchId outId,
    output IFetchPkg::QueueCount freeCount
);
    import IFetchPkg::*;

    Addr pcMem [QUEUE_DEPTH];
    Word instrMem [QUEUE_DEPTH];
    FetchId idMem [QUEUE_DEPTH];

    QueuePtr wrPtr;
    QueuePtr rdPtr;
    QueueCount count;
    logic pop;

    assign pop = outValid && outReady;

    always_ff @(posedge clk) begin
        if (pushValid) begin
            pcMem[wrPtr] <= pushPc;
            instrMem[wrPtr] <= pushInstr;
            idMem[wrPtr] <= pushId;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) wrPtr <= wrPtr + 1'b1;
            if (pop) rdPtr <= rdPtr + 1'b1;
            case ({pushValid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign outValid = count != '0;
    assign outPc = pcMem[rdPtr];
    assign outInstr = instrMem[rdPtr];
    assign outId = idMem[rdPtr];
    assign freeCount = QueueCount'(QUEUE_DEPTH) - count;

endmodule

// File: src/IFetchTop.sv
module IFetchTop (
    input  logic clk,
    input  logic rst,
    input  logic fetchValid,
    input  IFetchPkg::Addr fetchPc,
    input  logic clearCache,
    input  logic memBusy,
    input  logic memRespValid,
    input  IFetchPkg::Line memRespData,
    input  logic outReady,
    output logic stall,
    output logic memReq,
    output IFetchPkg::Addr memReqAddr,
    output logic outValid,
    output IFetchPkg::Addr outPc,
    output IFetchPkg::Word outInstr,
    output IFetchPkg::FetchId outId
);
    import IFetchPkg::*;

    logic flushActive;
    logic flushBusy;
    logic counterRun;
    logic counterDone;
    WayIdx flushWay;
    SetIdx flushSet;
    logic pipeEmpty;

    logic tagReadEn;
    SetIdx tagSet;
    Tag tagCmp;
    logic tagWe;
    WayIdx tagWay;
    Tag tagWriteTag;
    logic dataWe;
    logic hit;
    WayIdx hitWay;
    Line [WAYS-1:0] readLines;

    logic pushValid;
    Addr pushPc;
    Word pushInstr;
    FetchId pushId;
    QueueCount freeCount;

    FlushControl flushControl (
        .clk(clk),
        .rst(rst),
        .clearCache(clearCache),
        .pipeEmpty(pipeEmpty),
        .memBusy(memBusy),
        .counterDone(counterDone),
        .flushActive(flushActive),
        .flushBusy(flushBusy),
        .counterRun(counterRun)
    );

    FlushCounter flushCounter (
        .clk(clk),
        .rst(rst),
        .counterRun(counterRun),
        .flushWay(flushWay),
        .flushSet(flushSet),
        .counterDone(counterDone)
    );

    // flush walk owns the tag write port while active and writes invalid entries
    ICacheTags cacheTags (
        .clk(clk),
        .rst(rst),
        .readEn(tagReadEn),
        .readSet(tagSet),
        .readTag(tagCmp),
        .writeEn(flushActive || tagWe),
        .writeSet(flushActive ? flushSet : tagSet),
        .writeWay(flushActive ? flushWay : tagWay),
        .writeValid(!flushActive),
        .writeTag(tagWriteTag),
        .hit(hit),
        .hitWay(hitWay)
    );

    ICacheData cacheData (
        .clk(clk),
        .readEn(tagReadEn),
        .readSet(tagSet),
        .writeEn(dataWe),
        .writeSet(tagSet),
        .writeWay(tagWay),
        .writeLine(memRespData),
        .readLines(readLines)
    );

    FetchPipeline fetchPipeline (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .flushBusy(flushBusy),
        .hit(hit),
        .hitWay(hitWay),
        .readLines(readLines),
        .memRespValid(memRespValid),
        .memRespData(memRespData),
        .freeCount(freeCount),
        .stall(stall),
        .pipeEmpty(pipeEmpty),
        .tagReadEn(tagReadEn),
        .tagSet(tagSet),
        .tagCmp(tagCmp),
        .tagWe(tagWe),
        .tagWay(tagWay),
        .tagWriteTag(tagWriteTag),
        .dataWe(dataWe),
        .memReq(memReq),
        .memReqAddr(memReqAddr),
        .pushValid(pushValid),
        .pushPc(pushPc),
        .pushInstr(pushInstr),
        .pushId(pushId)
    );

    FetchQueue fetchQueue (
        .clk(clk),
        .rst(rst),
        .pushValid(pushValid),
        .pushPc(pushPc),
        .pushInstr(pushInstr),
        .pushId(pushId),
        .outReady(outReady),
        .outValid(outValid),
        .outPc(outPc),
        .outInstr(outInstr),
        .outId(outId),
        .freeCount(freeCount)
    );

endmodule

// File: verification/IFetchModel.svh
`ifndef IFETCH_MODEL_SVH
`define IFETCH_MODEL_SVH

localparam int LINE_BYTES = LINE_WORDS * 4;

// memory image, every word mixes all bits of its byte address
function automatic Word memWord(Addr a);
    return (a * 32'h9e37_79b9) ^ {a[7:0], a[31:8]} ^ 32'h3c6e_f372;
endfunction

function automatic Line lineData(Addr base);
    Line data;
    for (int i = 0; i < LINE_WORDS; i++) begin
        data[i] = memWord(base + Addr'(i * 4));
    end
    return data;
endfunction

function automatic Addr lineBase(Addr pc);
    return pc - (pc % Addr'(LINE_BYTES));
endfunction

function automatic int setOf(Addr pc);
    return int'((pc / Addr'(LINE_BYTES)) % Addr'(SETS));
endfunction

// residency mirror, line base address per way and set
Addr residentLine [WAYS][SETS];
bit residentValid [WAYS][SETS];
int victim;

// expected packets in acceptance order
// expMissQ holds the miss number of each packet, -1 for a hit
Addr expPcQ [$];
int expMissQ [$];
Addr refillQ [$];
FetchId expId;
int missTotal;
int reqSeen;

task automatic modelFlush;
    for (int w = 0; w < WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
            residentValid[w][s] = 1'b0;
        end
    end
endtask

task automatic modelReset;
    modelFlush();
    victim = 0;
    expId = '0;
    missTotal = 0;
    reqSeen = 0;
endtask

// hit check, on a miss the round-robin way takes the line
function automatic bit modelLookup(Addr pc);
    int s;
    Addr base;
    bit found;
    s = setOf(pc);
    base = lineBase(pc);
    found = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
        if (residentValid[w][s] && residentLine[w][s] == base) found = 1'b1;
    end
    if (!found) begin
        residentLine[victim][s] = base;
        residentValid[victim][s] = 1'b1;
        victim = (victim + 1) % WAYS;
    end
    return found;
endfunction

`endif

// File: verification/IFetchTb.sv
module IFetchTb;
    import IFetchPkg::*;

    logic clk;
    logic rst;
    logic fetchValid;
    Addr fetchPc;
    logic clearCache;
    logic memBusy;
    logic memRespValid;
    Line memRespData;
    logic outReady;
    logic stall;
    logic memReq;
    Addr memReqAddr;
    logic outValid;
    Addr outPc;
    Word outInstr;
    FetchId outId;

    `include "IFetchModel.svh"

    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 5;
    localparam int NUM_REQ = 300;
    localparam int MAX_DELAY = 8;
    localparam int MAX_CLEARS = 6;
    localparam int DRAIN_CYCLES = 20;
    // walk plus queueing and a short finalize
    localparam int FLUSH_CYCLES = WAYS * SETS + 16;
    // miss round trip plus consumer back-pressure
    localparam int REQ_CYCLES = MAX_DELAY + 16;
    localparam int TIMEOUT = RESET_CYCLES + (MAX_CLEARS + 1) * FLUSH_CYCLES
        + NUM_REQ * REQ_CYCLES + DRAIN_CYCLES;

    // three tags over four sets give conflict misses
    localparam int TAG_BASE = 32'h005c_3a10;
    localparam int LINE_SHIFT = $clog2(LINE_BYTES);
    localparam int TAG_SHIFT = $clog2(LINE_BYTES * SETS);

    int seed;
    int cycles;
    int acceptCount;
    int clearCount;
    int bootCycles;
    bit bootDone;
    bit respPending;
    int respWait;
    Addr respAddr;

    IFetchTop IFetchTop_i (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .clearCache(clearCache),
        .memBusy(memBusy),
        .memRespValid(memRespValid),
        .memRespData(memRespData),
        .outReady(outReady),
        .stall(stall),
        .memReq(memReq),
        .memReqAddr(memReqAddr),
        .outValid(outValid),
        .outPc(outPc),
        .outInstr(outInstr),
        .outId(outId)
    );

    always #50 clk = ~clk;

    task automatic failRun;
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkPacket(Addr gotPc, Word gotInstr, FetchId gotId,
                               Addr wantPc, Word wantInstr, FetchId wantId);
        if (gotPc !== wantPc) begin
            $display("mismatch at %0t: outPc got %h expected %h", $time, gotPc, wantPc);
            failRun();
        end
        if (gotInstr !== wantInstr) begin
            $display("mismatch at %0t: outInstr got %h expected %h", $time, gotInstr, wantInstr);
            failRun();
        end
        if (gotId !== wantId) begin
            $display("mismatch at %0t: outId got %h expected %h", $time, gotId, wantId);
            failRun();
        end
    endtask

    task automatic checkRefill(Addr got, Addr want);
        if (got !== want) begin
            $display("mismatch at %0t: memReqAddr got %h expected %h", $time, got, want);
            failRun();
        end
    endtask

    function automatic Addr pickPc(logic [31:0] r);
        int tagSel;
        int setSel;
        int wordSel;
        tagSel = int'(r[7:0]) % 3;
        setSel = int'(r[9:8]) * 5;
        wordSel = int'(r[11:10]);
        return (Addr'(TAG_BASE + tagSel) << TAG_SHIFT) | (Addr'(setSel) << LINE_SHIFT)
            | (Addr'(wordSel) << 2);
    endfunction

    // outputs and inputs are both stable at the falling edge
    task automatic sampleCycle;
        logic [31:0] rnd;
        Addr wantPc;
        int missNo;
        bit hitNow;
        rnd = $random(seed);
        if (!bootDone) begin
            if (memReq || outValid) begin
                $display("error at %0t: refill request or packet during the reset flush", $time);
                failRun();
            end
            bootCycles++;
            if (!stall) begin
                bootDone = 1'b1;
                if (bootCycles < WAYS * SETS) begin
                    $display("error at %0t: reset flush ended after %0d cycles", $time, bootCycles);
                    failRun();
                end
            end
        end
        // the first cycle with stall low can already accept a request
        if (bootDone) begin
            if (memReq) begin
                if (refillQ.size() == 0) begin
                    $display("error at %0t: refill request for %h without a predicted miss",
                             $time, memReqAddr);
                    failRun();
                end else begin
                    checkRefill(memReqAddr, refillQ.pop_front());
                    reqSeen++;
                    respPending = 1'b1;
                    respWait = int'(rnd[2:0]);
                    respAddr = memReqAddr;
                end
            end
            if (outValid && outReady) begin
                if (expPcQ.size() == 0) begin
                    $display("error at %0t: packet for %h with none expected", $time, outPc);
                    failRun();
                end else begin
                    wantPc = expPcQ.pop_front();
                    missNo = expMissQ.pop_front();
                    if (missNo >= reqSeen) begin
                        $display("error at %0t: packet for %h before its refill request",
                                 $time, wantPc);
                        failRun();
                    end
                    checkPacket(outPc, outInstr, outId, wantPc, memWord(wantPc), expId);
                    expId++;
                end
            end
            // the accept is looked up before a clear on the same edge
            if (fetchValid && !stall) begin
                expPcQ.push_back(fetchPc);
                hitNow = modelLookup(fetchPc);
                if (hitNow) begin
                    expMissQ.push_back(-1);
                end else begin
                    expMissQ.push_back(missTotal);
                    refillQ.push_back(lineBase(fetchPc));
                    missTotal++;
                end
                acceptCount++;
            end
            if (clearCache) modelFlush();
        end
    endtask

    task automatic driveCycle;
        logic [31:0] ctl;
        logic [31:0] pcRnd;
        ctl = $random(seed);
        pcRnd = $random(seed);
        if (respPending && respWait == 0) begin
            memRespValid = 1'b1;
            memRespData = lineData(respAddr);
            respPending = 1'b0;
        end else begin
            memRespValid = 1'b0;
            if (respPending) respWait--;
        end
        memBusy = respPending || memRespValid || ctl[0];
        outReady = ctl[3:2] != 2'd0;
        fetchValid = acceptCount < NUM_REQ && ctl[5:4] != 2'd0;
        fetchPc = pickPc(pcRnd);
        // only pulsed while stall is low and the flush FSM is idle
        clearCache = bootDone && !stall && clearCount < MAX_CLEARS
            && acceptCount < NUM_REQ && ctl[11:6] == 6'd0;
        if (clearCache) clearCount++;
    endtask

    task automatic runCycle;
        @(negedge clk);
        sampleCycle();
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("error at %0t: timeout after %0d cycles with %0d of %0d requests accepted",
                     $time, cycles, acceptCount, NUM_REQ);
            failRun();
        end
        @(posedge clk);
        #DRIVE_DELAY;
        driveCycle();
    endtask

    initial begin
        seed = 32'hd2da_6c4a;
        clk = 1'b0;
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchPc = '0;
        clearCache = 1'b0;
        memBusy = 1'b0;
        memRespValid = 1'b0;
        memRespData = '0;
        outReady = 1'b0;
        cycles = 0;
        acceptCount = 0;
        clearCount = 0;
        bootCycles = 0;
        bootDone = 1'b0;
        respPending = 1'b0;
        respWait = 0;
        respAddr = '0;
        modelReset();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        while (!(acceptCount == NUM_REQ && expPcQ.size() == 0)) begin
            runCycle();
        end
        // quiet tail still catches a stray packet or request
        repeat (DRAIN_CYCLES) runCycle();

        if (refillQ.size() != 0 || reqSeen != missTotal) begin
            $display("error at %0t: %0d refill requests seen, %0d misses predicted",
                     $time, reqSeen, missTotal);
            failRun();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+verification
src/IFetchPkg.sv
src/FlushControl.sv
src/FlushCounter.sv
src/ICacheTags.sv
src/ICacheData.sv
src/FetchPipeline.sv
src/FetchQueue.sv
src/IFetchTop.sv
verification/IFetchTb.sv

// File: run.sh
#!/bin/sh
# build and run, exit status is the verdict
cd "$(dirname "$0")" \
    && verilator --binary -j 0 --top-module IFetchTb -f list.f -o IFetchSim \
    && ./obj_dir/IFetchSim \
    || exit 1
